//--- Makefile
# Verilator lint and simulation of the SDRAM controller testbench
VERILATOR = verilator
FLAGS = --timing --assert
TOP = tb_sdramController
FILELIST = project.f
OBJDIR = obj_dir
LOG = sim.log
RUNARGS = +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) $(RUNARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "All tests passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- include/sdramTiming_macros.svh
// Build-time sizes and delays for the SDRAM controller
// included by the packages and by every block that loads a timer
// delays are clock counts, shortened for simulation
`ifndef SDRAM_TIMING_MACROS_SVH
`define SDRAM_TIMING_MACROS_SVH

// bus widths
`define SDRAM_ROW_W 13
`define SDRAM_COL_W 10
`define SDRAM_BANK_W 2
`define DATA_W 16
`define TIMER_W 16

// init sequence
`define POWERUP_CYCLES 32
`define INIT_REFRESH_CYCLES 40
`define REFRESH_NOP_CYCLES 3
`define MODE_NOP_CYCLES 3

// access and refresh
`define CAS_CYCLES 2
`define REFRESH_INTERVAL 32

// mode register fields, A2..A0 burst length code and A6..A4 CAS latency
`define MODE_BURST_LEN 0
`define MODE_CAS_LAT 2

`endif

//--- project.f
+incdir+include
src/sdramCmdPkg.sv
src/cpuBusPkg.sv
src/dramTimers.sv
src/dramSequencer.sv
src/dramDataPath.sv
src/sdramController.sv
testbench/sdramController_properties.sv
testbench/tb_sdramController.sv

//--- src/cpuBusPkg.sv
// CPU-side types for the 68000-style bus
// the request struct bundles every pin the CPU drives toward the controller
// users refer to them as cpuBusPkg::name
`default_nettype none
`include "sdramTiming_macros.svh"

package cpuBusPkg;

	typedef logic [31:0] cpuAddr_t;			// byte address
	typedef logic [`DATA_W-1:0] cpuData_t;	// one bus word

	// strobes are levels, all active low
	typedef struct packed {
		cpuAddr_t address;
		cpuData_t dataIn;		// write data from the CPU
		logic     udsL;			// upper byte strobe
		logic     ldsL;			// lower byte strobe
		logic     dramSelectL;	// address decode hit on the SDRAM range
		logic     weL;			// low for write, high for read
		logic     asL;			// address strobe
	} cpuReq_t;	// 53 bits

endpackage

`default_nettype wire

//--- src/dramDataPath.sv
// Output side of the SDRAM controller
// builds row, column or mode word from the CPU address and registers
// every SDRAM pin and CPU handshake one clock after the sequencer picks it
// read data is captured on the rising edge into DataOut
`default_nettype none
`include "sdramTiming_macros.svh"

module dramDataPath (
	input  wire logic                       Clock,
	input  wire logic                       Reset_L,
	input  wire cpuBusPkg::cpuReq_t         Cpu,
	input  wire sdramCmdPkg::sdramCmd_e     NextCmd,
	input  wire sdramCmdPkg::sdramAddrSel_e AddrSel,
	input  wire logic                       WriteDrive,
	input  wire logic                       CaptureRead,
	input  wire logic                       DtackNext,
	input  wire logic                       CpuResetNext,
	input  wire cpuBusPkg::cpuData_t        DqIn,
	output sdramCmdPkg::sdramPins_t         SdramPins,
	output logic                            SdramCke,
	output cpuBusPkg::cpuData_t             DqOut,
	output logic                            DqOutEnable,
	output cpuBusPkg::cpuData_t             DataOut,
	output logic                            Dtack_L,
	output logic                            ResetOut_L
);

	sdramCmdPkg::sdramRow_t   rowAddr;
	sdramCmdPkg::sdramCol_t   colAddr;
	sdramCmdPkg::sdramBank_t  bankAddr;
	sdramCmdPkg::sdramAddr_t  modeWord;
	sdramCmdPkg::sdramPins_t  nextPins;

	assign rowAddr = Cpu.address[23:11];
	assign bankAddr = Cpu.address[25:24];
	assign colAddr = Cpu.address[10:1];	// word address, bit 0 is the byte lane
	// burst type, op mode and write burst mode all zero
	assign modeWord = sdramCmdPkg::sdramAddr_t'({3'(`MODE_CAS_LAT), 1'b0, 3'(`MODE_BURST_LEN)});

	////////////////////
	// address mux
	always_comb begin
		nextPins.cmd = NextCmd;
		nextPins.addr = '0;
		nextPins.bank = '0;
		case (AddrSel)
			sdramCmdPkg::AddrRow: begin
				nextPins.addr = rowAddr;
				nextPins.bank = bankAddr;
			end
			sdramCmdPkg::AddrCol: begin
				// A10 sits just above the column bits, high for auto-precharge
				nextPins.addr = sdramCmdPkg::sdramAddr_t'({1'b1, colAddr});
				nextPins.bank = bankAddr;
			end
			sdramCmdPkg::AddrMode:
				nextPins.addr = modeWord;	// BA stays zero for the mode register
			default:
				nextPins.addr[`SDRAM_COL_W] = (NextCmd == sdramCmdPkg::PrechargeAll);
		endcase
	end

	////////////////////
	// registered pins and handshakes
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			SdramPins <= '{cmd: sdramCmdPkg::PowerUp, addr: '0, bank: '0};
			DqOutEnable <= 1'b0;
			Dtack_L <= 1'b1;
			ResetOut_L <= 1'b0;	// CPU held until init completes
		end else begin
			SdramPins <= nextPins;
			DqOutEnable <= WriteDrive;
			Dtack_L <= !DtackNext;
			ResetOut_L <= CpuResetNext;
		end
	end

	assign SdramCke = SdramPins.cmd[4];	// top bit of the command code

	// write data out and read data back
	always_ff @(posedge Clock) begin
		if (WriteDrive)
			DqOut <= Cpu.dataIn;
		if (CaptureRead)
			DataOut <= DqIn;
	end

endmodule

`default_nettype wire

//--- src/dramSequencer.sv
// Control FSM of the SDRAM controller
// runs power-up, the init refresh loop and mode set, then serves
// refreshes and single-word CPU reads and writes from idle
// all outputs are combinational from state and get registered in the data path
`default_nettype none
`include "sdramTiming_macros.svh"

module dramSequencer (
	input  wire logic                          Clock,
	input  wire logic                          Reset_L,
	input  wire cpuBusPkg::cpuReq_t            Cpu,
	input  wire logic                          TimerDone,
	input  wire logic                          RefreshDue,
	output logic                               TimerLoad,
	output logic [`TIMER_W-1:0]                TimerValue,
	output logic                               RefreshLoad,
	output sdramCmdPkg::sdramCmd_e             NextCmd,
	output sdramCmdPkg::sdramAddrSel_e         AddrSel,
	output logic                               WriteDrive,		// drive DQ next cycle
	output logic                               CaptureRead,		// latch DqIn this edge
	output logic                               DtackNext,		// acknowledge next cycle
	output logic                               CpuResetNext		// release CPU reset
);

	typedef enum logic [4:0] {
		InitLoad, InitWait, InitNop1, InitNop2,
		InitRefresh, InitRefreshNop, InitModeSet, InitModeNop, InitLoadRefresh,
		Idle, RefPrechargeNop, RefRefresh, RefNop,
		WriteCmd, WriteHold, ReadCmd, ReadWait, BusEnd
	} dramState_e;

	dramState_e state;
	dramState_e nextState;
	logic [3:0] nopCount;		// NOPs left after a refresh
	logic       nopLoad;
	logic       strobeActive;	// either data strobe low
	logic       cpuRequest;		// SDRAM selected with AS

	assign strobeActive = !Cpu.udsL || !Cpu.ldsL;
	assign cpuRequest = !Cpu.dramSelectL && !Cpu.asL;

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= InitLoad;
			nopCount <= '0;
		end else begin
			state <= nextState;
			if (nopLoad)
				nopCount <= 4'(`REFRESH_NOP_CYCLES - 1);
			else if (nopCount != '0)
				nopCount <= nopCount - 1'b1;
		end
	end

	////////////////////
	// next state and outputs
	always_comb begin
		nextState = state;
		NextCmd = sdramCmdPkg::Nop;
		AddrSel = sdramCmdPkg::AddrNone;
		TimerLoad = 1'b0;
		TimerValue = '0;
		RefreshLoad = 1'b0;
		nopLoad = 1'b0;
		WriteDrive = 1'b0;
		CaptureRead = 1'b0;
		DtackNext = 1'b0;
		CpuResetNext = 1'b1;	// CPU runs outside init
		case (state)
			InitLoad: begin
				NextCmd = sdramCmdPkg::PowerUp;
				CpuResetNext = 1'b0;
				TimerLoad = 1'b1;
				TimerValue = `TIMER_W'(`POWERUP_CYCLES);
				nextState = InitWait;
			end
			InitWait: begin
				NextCmd = sdramCmdPkg::PowerUp;	// hold until supply settles
				CpuResetNext = 1'b0;
				if (TimerDone)
					nextState = InitNop1;
			end
			InitNop1: begin
				CpuResetNext = 1'b0;
				nextState = InitNop2;
			end
			InitNop2: begin
				CpuResetNext = 1'b0;
				TimerLoad = 1'b1;	// opens the init refresh window
				TimerValue = `TIMER_W'(`INIT_REFRESH_CYCLES);
				nextState = InitRefresh;
			end
			InitRefresh: begin
				NextCmd = sdramCmdPkg::Refresh;
				CpuResetNext = 1'b0;
				nopLoad = 1'b1;
				nextState = InitRefreshNop;
			end
			InitRefreshNop: begin
				CpuResetNext = 1'b0;
				if (nopCount == '0)
					nextState = TimerDone ? InitModeSet : InitRefresh;	// repeat inside window
			end
			InitModeSet: begin
				NextCmd = sdramCmdPkg::ModeSet;
				AddrSel = sdramCmdPkg::AddrMode;
				CpuResetNext = 1'b0;
				TimerLoad = 1'b1;
				TimerValue = `TIMER_W'(`MODE_NOP_CYCLES);
				nextState = InitModeNop;
			end
			InitModeNop: begin
				CpuResetNext = 1'b0;
				if (TimerDone)
					nextState = InitLoadRefresh;
			end
			InitLoadRefresh: begin
				CpuResetNext = 1'b0;
				RefreshLoad = 1'b1;	// first interval starts here
				nextState = Idle;
			end
			Idle: begin
				if (RefreshDue) begin	// refresh beats a waiting CPU
					NextCmd = sdramCmdPkg::PrechargeAll;
					nextState = RefPrechargeNop;
				end else if (cpuRequest) begin
					NextCmd = sdramCmdPkg::Activate;
					AddrSel = sdramCmdPkg::AddrRow;
					nextState = Cpu.weL ? ReadCmd : WriteCmd;
				end
			end
			RefPrechargeNop:
				nextState = RefRefresh;
			RefRefresh: begin
				NextCmd = sdramCmdPkg::Refresh;
				nopLoad = 1'b1;
				nextState = RefNop;
			end
			RefNop: begin
				if (nopCount == '0) begin
					RefreshLoad = 1'b1;
					nextState = Idle;
				end
			end
			WriteCmd: begin
				if (strobeActive) begin	// wait for valid write data
					NextCmd = sdramCmdPkg::Write;
					AddrSel = sdramCmdPkg::AddrCol;
					WriteDrive = 1'b1;
					DtackNext = 1'b1;
					nextState = WriteHold;
				end
			end
			WriteHold: begin
				WriteDrive = 1'b1;	// one more cycle of data
				DtackNext = 1'b1;
				nextState = BusEnd;
			end
			ReadCmd: begin
				NextCmd = sdramCmdPkg::Read;
				AddrSel = sdramCmdPkg::AddrCol;
				TimerLoad = 1'b1;
				TimerValue = `TIMER_W'(`CAS_CYCLES);
				nextState = ReadWait;
			end
			ReadWait: begin
				if (TimerDone) begin
					CaptureRead = 1'b1;	// data on DqIn now
					nextState = BusEnd;
				end
			end
			BusEnd: begin
				if (strobeActive)
					DtackNext = 1'b1;	// hold ack until CPU lets go
				else
					nextState = Idle;
			end
			default:
				nextState = Idle;
		endcase
	end

endmodule

`default_nettype wire

//--- src/dramTimers.sv
// Delay timer and refresh interval timer for the SDRAM sequencer
// both count down once per clock and stop at zero
// a load takes effect on the next edge, done and due are levels
`default_nettype none
`include "sdramTiming_macros.svh"

module dramTimers (
	input  wire logic                Clock,
	input  wire logic                Reset_L,
	input  wire logic                TimerLoad,		// load TimerValue next edge
	input  wire logic [`TIMER_W-1:0] TimerValue,
	output logic                     TimerDone,		// high while count is zero
	input  wire logic                RefreshLoad,	// restart refresh interval
	output logic                     RefreshDue		// high while interval expired
);

	logic [`TIMER_W-1:0] timerCount;	// general delay
	logic [`TIMER_W-1:0] refreshCount;	// cycles left to next refresh

	////////////////////
	// general delay counter
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L)
			timerCount <= '0;
		else if (TimerLoad)
			timerCount <= TimerValue;
		else if (timerCount != '0)
			timerCount <= timerCount - 1'b1;	// hold at zero
	end

	assign TimerDone = (timerCount == '0);

	////////////////////
	// refresh interval counter, load value fixed at build time
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L)
			refreshCount <= '0;
		else if (RefreshLoad)
			refreshCount <= `TIMER_W'(`REFRESH_INTERVAL);
		else if (refreshCount != '0)
			refreshCount <= refreshCount - 1'b1;
	end

	assign RefreshDue = (refreshCount == '0);

endmodule

`default_nettype wire

//--- src/sdramCmdPkg.sv
// SDRAM-side types shared by the controller blocks
// command codes, the registered pin bundle and address fields
// users refer to them as sdramCmdPkg::name
`default_nettype none
`include "sdramTiming_macros.svh"

package sdramCmdPkg;

	typedef logic [`SDRAM_ROW_W-1:0] sdramRow_t;	// row address
	typedef logic [`SDRAM_COL_W-1:0] sdramCol_t;	// column address
	typedef logic [`SDRAM_BANK_W-1:0] sdramBank_t;	// bank select
	typedef logic [`SDRAM_ROW_W-1:0] sdramAddr_t;	// A12..A0, as wide as a row

	// code bits are {CKE, CS_L, RAS_L, CAS_L, WE_L}
	typedef enum logic [4:0] {
		PowerUp      = 5'b00000,	// CKE and CS low while power settles
		Nop          = 5'b10111,
		Activate     = 5'b10011,	// opens the row on BA
		Read         = 5'b10101,	// A10 high gives auto-precharge
		Write        = 5'b10100,	// A10 high gives auto-precharge
		Refresh      = 5'b10001,	// auto-refresh
		PrechargeAll = 5'b10010,	// needs A10 high
		ModeSet      = 5'b10000		// mode word on A, BA zero
	} sdramCmd_e;

	// what the address pins carry next cycle
	typedef enum logic [1:0] {
		AddrNone,
		AddrRow,
		AddrCol,
		AddrMode
	} sdramAddrSel_e;

	typedef struct packed {
		sdramCmd_e  cmd;
		sdramAddr_t addr;
		sdramBank_t bank;
	} sdramPins_t;	// 20 bits

endpackage

`default_nettype wire

//--- src/sdramController.sv
// SDRAM controller top level for a 68000-style CPU
// connects the timers, the sequencer FSM and the data path
// the DQ pad with its tristate buffer lives outside this block
`default_nettype none
`include "sdramTiming_macros.svh"

module sdramController (
	input  wire logic                Clock,
	input  wire logic                Reset_L,
	input  wire cpuBusPkg::cpuReq_t  Cpu,
	input  wire cpuBusPkg::cpuData_t DqIn,
	output sdramCmdPkg::sdramPins_t  SdramPins,
	output logic                     SdramCke,
	output cpuBusPkg::cpuData_t      DqOut,
	output logic                     DqOutEnable,
	output cpuBusPkg::cpuData_t      DataOut,
	output logic                     Dtack_L,
	output logic                     ResetOut_L
);

	logic                       timerLoad;
	logic [`TIMER_W-1:0]        timerValue;
	logic                       timerDone;
	logic                       refreshLoad;
	logic                       refreshDue;
	sdramCmdPkg::sdramCmd_e     nextCmd;
	sdramCmdPkg::sdramAddrSel_e addrSel;
	logic                       writeDrive;
	logic                       captureRead;
	logic                       dtackNext;
	logic                       cpuResetNext;

	dramTimers timers (
		.Clock(Clock), .Reset_L(Reset_L),
		.TimerLoad(timerLoad), .TimerValue(timerValue), .TimerDone(timerDone),
		.RefreshLoad(refreshLoad), .RefreshDue(refreshDue)
	);

	dramSequencer sequencer (
		.Clock(Clock), .Reset_L(Reset_L), .Cpu(Cpu),
		.TimerDone(timerDone), .RefreshDue(refreshDue),
		.TimerLoad(timerLoad), .TimerValue(timerValue), .RefreshLoad(refreshLoad),
		.NextCmd(nextCmd), .AddrSel(addrSel),
		.WriteDrive(writeDrive), .CaptureRead(captureRead),
		.DtackNext(dtackNext), .CpuResetNext(cpuResetNext)
	);

	dramDataPath dataPath (
		.Clock(Clock), .Reset_L(Reset_L), .Cpu(Cpu),
		.NextCmd(nextCmd), .AddrSel(addrSel),
		.WriteDrive(writeDrive), .CaptureRead(captureRead),
		.DtackNext(dtackNext), .CpuResetNext(cpuResetNext),
		.DqIn(DqIn), .SdramPins(SdramPins), .SdramCke(SdramCke),
		.DqOut(DqOut), .DqOutEnable(DqOutEnable),
		.DataOut(DataOut), .Dtack_L(Dtack_L), .ResetOut_L(ResetOut_L)
	);

endmodule

`default_nettype wire

//--- testbench/sdramController_properties.sv
// Concurrent checks on the SDRAM and CPU pins of the controller
// bound into the sdramController top level, a failing check raises $error
`default_nettype none

module sdramControllerProperties (
	input wire logic                    Clock,
	input wire logic                    Reset_L,
	input wire cpuBusPkg::cpuReq_t      Cpu,
	input wire sdramCmdPkg::sdramPins_t SdramPins,
	input wire logic                    DqOutEnable,
	input wire logic                    Dtack_L,
	input wire logic                    ResetOut_L
);

	int unsigned failCount = 0;	// failed checks so far

	// no row traffic while the CPU is held in reset
	noAccessInInit: assert property (@(posedge Clock) disable iff (!Reset_L)
		!ResetOut_L |-> !(SdramPins.cmd inside
			{sdramCmdPkg::Activate, sdramCmdPkg::Read, sdramCmdPkg::Write}))
		else begin
			failCount++;
			$error("access command issued while ResetOut_L low");
		end

	// DQ driven in the write cycle and the one after
	driveOnlyForWrite: assert property (@(posedge Clock) disable iff (!Reset_L)
		DqOutEnable |-> (SdramPins.cmd == sdramCmdPkg::Write
			|| $past(SdramPins.cmd) == sdramCmdPkg::Write))
		else begin
			failCount++;
			$error("DqOutEnable high outside a write");
		end

	// ack is registered, so it follows the select one clock late
	noAckWithoutSelect: assert property (@(posedge Clock) disable iff (!Reset_L)
		Cpu.dramSelectL |=> Dtack_L)
		else begin
			failCount++;
			$error("Dtack_L low while SDRAM not selected");
		end

endmodule

bind sdramController sdramControllerProperties pinChecks (
	.Clock(Clock), .Reset_L(Reset_L), .Cpu(Cpu), .SdramPins(SdramPins),
	.DqOutEnable(DqOutEnable), .Dtack_L(Dtack_L), .ResetOut_L(ResetOut_L)
);

`default_nettype wire

//--- testbench/tb_sdramController.sv
// Testbench for the SDRAM controller
// runs the init sequence, then a table of writes and reads against a small
// SDRAM model, checking pins, CPU handshake and refresh spacing on the way
`default_nettype none
`include "sdramTiming_macros.svh"

module tb_sdramController;

	localparam int ClockPeriod = 100;
	localparam int NumPairs = 6;			// writes, then reads of the same words
	localparam int NumRows = 2 * NumPairs;
	localparam int MaxHold = 3;			// extra cycles the CPU keeps its strobes
	localparam int ReleaseBound = 3;		// strobe release to Dtack_L high
	localparam int InitBound = 2 * (`POWERUP_CYCLES + `INIT_REFRESH_CYCLES
		+ `MODE_NOP_CYCLES + 8);
	// activate, CAS wait, ack, hold, release, then precharge and refresh NOPs
	localparam int LongestAccess = 4 + `CAS_CYCLES + MaxHold + ReleaseBound
		+ `REFRESH_NOP_CYCLES + 3;
	localparam int RefreshGapMax = `REFRESH_INTERVAL + LongestAccess;
	localparam int AckBound = 2 * LongestAccess;
	localparam int WatchdogCycles = InitBound + NumRows * (AckBound + MaxHold + ReleaseBound + 2);

	typedef struct packed {
		logic                isWrite;
		cpuBusPkg::cpuAddr_t address;
		cpuBusPkg::cpuData_t data;
		cpuBusPkg::cpuData_t expected;	// read value, unused on writes
	} stimRow_t;

	logic Clock = 1'b0;
	logic Reset_L = 1'b0;
	cpuBusPkg::cpuReq_t cpu = '{address: '0, dataIn: '0, udsL: 1'b1, ldsL: 1'b1,
		dramSelectL: 1'b1, weL: 1'b1, asL: 1'b1};	// bus idle
	cpuBusPkg::cpuData_t dqIn = '0;
	sdramCmdPkg::sdramPins_t sdramPins;
	logic sdramCke;
	cpuBusPkg::cpuData_t dqOut;
	logic dqOutEnable;
	cpuBusPkg::cpuData_t dataOut;
	logic dtackL;
	logic resetOutL;

	stimRow_t stimTable [NumRows];
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int initRefreshes = 0;
	int modeSets = 0;
	int periodicRefreshes = 0;
	int lastRefreshCycle = -1;				// none since init
	sdramCmdPkg::sdramCmd_e lastCmd = sdramCmdPkg::Nop;	// last command other than Nop

	// SDRAM model state
	cpuBusPkg::cpuData_t memory [int];
	sdramCmdPkg::sdramRow_t openRow [4];
	cpuBusPkg::cpuData_t readData;
	int readDelay = 0;

	sdramController uut (
		.Clock(Clock), .Reset_L(Reset_L), .Cpu(cpu), .DqIn(dqIn),
		.SdramPins(sdramPins), .SdramCke(sdramCke), .DqOut(dqOut), .DqOutEnable(dqOutEnable),
		.DataOut(dataOut), .Dtack_L(dtackL), .ResetOut_L(resetOutL)
	);

	always #(ClockPeriod / 2) Clock = ~Clock;

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("** Error at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
		end
	endtask

	// clock until Dtack_L shows level or limit cycles pass
	task automatic waitDtack(input logic level, input int limit, output int cycles);
		cycles = 0;
		while (dtackL !== level && cycles < limit) begin
			@(posedge Clock);
			cycles++;
		end
	endtask

	// one CPU bus cycle, strobes held hold cycles past the ack
	task automatic applyRow(input stimRow_t row, input int hold);
		int waited;
		@(posedge Clock);
		cpu.address <= row.address;
		cpu.dataIn <= row.isWrite ? row.data : '0;
		cpu.weL <= !row.isWrite;
		cpu.asL <= 1'b0;
		cpu.dramSelectL <= 1'b0;
		cpu.udsL <= 1'b0;
		cpu.ldsL <= 1'b0;
		waitDtack(1'b0, AckBound, waited);
		if (dtackL !== 1'b0) begin
			errorCount++;
			$display("Timed out waiting for Dtack_L at address %h", row.address);
		end else if (!row.isWrite)
			checkValue(32'(dataOut), 32'(row.expected), "read data at ack");
		repeat (hold) begin
			@(posedge Clock);
			checkValue(32'(dtackL), 0, "Dtack_L held while strobes low");
			if (!row.isWrite)
				checkValue(32'(dataOut), 32'(row.expected), "read data during hold");
		end
		cpu.asL <= 1'b1;	// release on this edge
		cpu.dramSelectL <= 1'b1;
		cpu.udsL <= 1'b1;
		cpu.ldsL <= 1'b1;
		waitDtack(1'b1, ReleaseBound, waited);
		if (dtackL !== 1'b1) begin
			errorCount++;
			$display("Dtack_L did not rise within %0d cycles of release", ReleaseBound);
		end
	endtask

	////////////////////
	// SDRAM model, sees the command registered on the previous edge
	always @(posedge Clock) begin : sdramModel
		int key;
		key = {7'b0, sdramPins.bank, openRow[sdramPins.bank], sdramPins.addr[`SDRAM_COL_W-1:0]};
		dqIn <= '0;	// idle bus pattern
		if (readDelay != 0) begin
			readDelay <= readDelay - 1;
			if (readDelay == 1)
				dqIn <= readData;	// CAS latency reached
		end
		if (sdramPins.cmd == sdramCmdPkg::Activate)
			openRow[sdramPins.bank] <= sdramPins.addr;
		else if (sdramPins.cmd == sdramCmdPkg::Write) begin
			memory[key] = dqOut;
			checkValue(32'(dqOutEnable), 1, "DQ driven with write");
		end else if (sdramPins.cmd == sdramCmdPkg::Read) begin
			readData <= memory.exists(key) ? memory[key] : '0;
			readDelay <= `CAS_CYCLES - 1;
		end
	end

	////////////////////
	// pin monitor for init, address mapping and refresh spacing
	always @(posedge Clock) begin : pinMonitor
		if (Reset_L) begin
			cycleCount++;
			checkValue(32'(sdramCke), 32'(sdramPins.cmd != sdramCmdPkg::PowerUp),
				"CKE low only during power-up");
			if (!resetOutL && sdramPins.cmd == sdramCmdPkg::Refresh)
				initRefreshes++;
			if (!resetOutL && sdramPins.cmd == sdramCmdPkg::ModeSet) begin
				modeSets++;
				checkValue(32'(sdramPins.addr[6:4]), `MODE_CAS_LAT, "mode word CAS latency");
				checkValue(32'(sdramPins.addr[2:0]), `MODE_BURST_LEN, "mode word burst length");
			end
			if (sdramPins.cmd == sdramCmdPkg::Activate) begin
				checkValue(32'(sdramPins.bank), 32'(cpu.address[25:24]), "bank on activate");
				checkValue(32'(sdramPins.addr), 32'(cpu.address[23:11]), "row on activate");
			end
			if (sdramPins.cmd == sdramCmdPkg::Read || sdramPins.cmd == sdramCmdPkg::Write) begin
				checkValue(32'(sdramPins.addr[9:0]), 32'(cpu.address[10:1]), "column address");
				checkValue(32'(sdramPins.addr[10]), 1, "A10 auto-precharge");
				checkValue(32'(sdramPins.bank), 32'(cpu.address[25:24]), "bank on access");
			end
			if (resetOutL && sdramPins.cmd == sdramCmdPkg::Refresh) begin
				periodicRefreshes++;
				if (lastRefreshCycle >= 0)
					checkValue(32'(cycleCount - lastRefreshCycle <= RefreshGapMax), 1,
						"refresh gap too long");
				checkValue(32'(lastCmd == sdramCmdPkg::PrechargeAll), 1,
					"precharge before refresh");
				lastRefreshCycle = cycleCount;
			end
			if (sdramPins.cmd != sdramCmdPkg::Nop)
				lastCmd = sdramPins.cmd;
		end
	end

	////////////////////
	initial begin
		int waited;
		void'($urandom(32'h5f01));
		for (int i = 0; i < NumPairs; i++) begin
			stimTable[i].isWrite = 1'b1;
			stimTable[i].address = $urandom;
			stimTable[i].address[3:1] = 3'(i);	// distinct column per pair
			stimTable[i].address[0] = 1'b0;
			stimTable[i].data = 16'($urandom);
			stimTable[i].expected = '0;
			stimTable[NumRows-1-i] = stimTable[i];	// read back in reverse order
			stimTable[NumRows-1-i].isWrite = 1'b0;
			stimTable[NumRows-1-i].expected = stimTable[i].data;
		end
		repeat (3) @(posedge Clock);
		Reset_L <= 1'b1;
		waited = 0;
		while (resetOutL !== 1'b1 && waited < InitBound) begin
			@(posedge Clock);
			waited++;
		end
		if (resetOutL !== 1'b1) begin
			errorCount++;
			$display("ResetOut_L never rose after power-up");
		end
		checkValue(32'(initRefreshes >= 2), 1, "at least two init refreshes");
		checkValue(32'(modeSets), 1, "one mode set during init");
		for (int i = 0; i < NumRows; i++)
			applyRow(stimTable[i], i % (MaxHold + 1));
		checkValue(32'(periodicRefreshes > 0), 1, "refresh after init");
		repeat (2) @(posedge Clock);
		errorCount += int'(uut.pinChecks.failCount);
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// watchdog sized from init length and table length
	initial begin
		#(WatchdogCycles * ClockPeriod);
		$display("Watchdog expired after %0d cycles, the controller stopped answering",
			WatchdogCycles);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
